/* design/uart_defs.svh */
// ================================================
// UART echo build constants.
// Clock rate, default baud rate, string buffer
// size and the idle gap that ends a string.
// ================================================
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// system clock frequency in hertz.
`define UART_CLK_FREQ 125000000

// default serial rate, used as the BAUD_RATE parameter default.
`define UART_BAUD_RATE 115200

// maximum number of bytes held in one string.
// the string bus is eight times this many bits wide.
`define UART_STR_MAX 128

// idle bit times after the last byte that close a received string.
`define UART_IDLE_BITS 20

`endif

/* design/uart_pkg.sv */
// ================================================
// UART echo shared types.
// Byte, length and FSM state types for the RTL.
// ================================================
`include "uart_defs.svh"

package uart_pkg;

    // one serial data byte.
    typedef logic [7:0] byte_t;

    // string length in bytes, wide enough for a full 128-byte buffer.
    typedef logic [7:0] str_len_t;

    // framing FSM shared by the byte receiver and the byte transmitter.
    typedef enum logic [1:0] {
        SER_IDLE,
        SER_START,
        SER_DATA,
        SER_STOP
    } ser_state_t;

    // string transmit sequencer states.
    typedef enum logic [1:0] {
        STR_IDLE,
        STR_LOAD,
        STR_SEND,
        STR_WAIT
    } str_state_t;

endpackage

/* design/uart_byte_rx.sv */
// ================================================
// UART 8N1 byte receiver.
// Synchronizes the line, samples at mid-bit and
// drops any frame whose stop bit is low.
// ================================================
`include "uart_defs.svh"

module uart_byte_rx #(
    parameter int BAUD_RATE = `UART_BAUD_RATE
) (
    input  logic               sys_clk,
    input  logic               sys_rst_n,
    input  logic               rx_line,
    output uart_pkg::byte_t    rx_byte,
    output logic               rx_valid
);

    // clock cycles per bit, rounded down.
    localparam int BIT_CYCLES = `UART_CLK_FREQ / BAUD_RATE;
    localparam int CNT_W = $clog2(BIT_CYCLES);

    logic                 rx_meta;
    logic                 rx_sync;
    uart_pkg::ser_state_t state;
    logic [CNT_W-1:0]     bit_cnt;
    logic [2:0]           bit_idx;
    uart_pkg::byte_t      shift_reg;

    // two-flop synchronizer; the line idles high so reset loads ones.
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            state    <= uart_pkg::SER_IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            // rx_valid is a single-cycle strobe.
            rx_valid <= 1'b0;
            case (state)
                uart_pkg::SER_IDLE: begin
                    bit_cnt <= '0;
                    if (!rx_sync) begin
                        state <= uart_pkg::SER_START;
                    end
                end
                uart_pkg::SER_START: begin
                    // look at the start bit again at its middle to reject glitches.
                    if (bit_cnt == CNT_W'(BIT_CYCLES / 2 - 1)) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? uart_pkg::SER_IDLE : uart_pkg::SER_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                uart_pkg::SER_DATA: begin
                    // a full bit period from one mid-bit lands on the next one.
                    if (bit_cnt == CNT_W'(BIT_CYCLES - 1)) begin
                        bit_cnt   <= '0;
                        shift_reg <= {rx_sync, shift_reg[7:1]};
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= uart_pkg::SER_STOP;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                uart_pkg::SER_STOP: begin
                    // a low stop bit is a framing error and the byte is lost.
                    if (bit_cnt == CNT_W'(BIT_CYCLES - 1)) begin
                        bit_cnt <= '0;
                        state   <= uart_pkg::SER_IDLE;
                        if (rx_sync) begin
                            rx_byte  <= shift_reg;
                            rx_valid <= 1'b1;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= uart_pkg::SER_IDLE;
            endcase
        end
    end

    // a byte is reported once, never on two adjacent cycles.
    a_rx_valid_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        rx_valid |=> !rx_valid);

endmodule

/* design/uart_byte_tx.sv */
// ================================================
// UART 8N1 byte transmitter.
// Sends start, eight data bits LSB first and stop.
// ================================================
`include "uart_defs.svh"

module uart_byte_tx #(
    parameter int BAUD_RATE = `UART_BAUD_RATE
) (
    input  logic               sys_clk,
    input  logic               sys_rst_n,
    input  logic               byte_req,
    input  uart_pkg::byte_t    byte_data,
    output logic               tx_line,
    output logic               byte_busy,
    output logic               byte_done
);

    localparam int BIT_CYCLES = `UART_CLK_FREQ / BAUD_RATE;
    localparam int CNT_W = $clog2(BIT_CYCLES);

    uart_pkg::ser_state_t state;
    logic [CNT_W-1:0]     bit_cnt;
    logic [2:0]           bit_idx;
    uart_pkg::byte_t      shift_reg;

    // end of the current bit period.
    logic bit_end;
    assign bit_end = (bit_cnt == CNT_W'(BIT_CYCLES - 1));

    // tx_line is registered so the pin never glitches between bits.
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            state     <= uart_pkg::SER_IDLE;
            tx_line   <= 1'b1;
            byte_busy <= 1'b0;
            byte_done <= 1'b0;
            bit_cnt   <= '0;
            bit_idx   <= '0;
        end else begin
            byte_done <= 1'b0;
            bit_cnt   <= bit_end ? '0 : bit_cnt + 1'b1;
            case (state)
                uart_pkg::SER_IDLE: begin
                    bit_cnt <= '0;
                    if (byte_req) begin
                        shift_reg <= byte_data;
                        tx_line   <= 1'b0;
                        byte_busy <= 1'b1;
                        state     <= uart_pkg::SER_START;
                    end
                end
                uart_pkg::SER_START: begin
                    if (bit_end) begin
                        tx_line <= shift_reg[0];
                        bit_idx <= '0;
                        state   <= uart_pkg::SER_DATA;
                    end
                end
                uart_pkg::SER_DATA: begin
                    if (bit_end) begin
                        shift_reg <= shift_reg >> 1;
                        bit_idx   <= bit_idx + 1'b1;
                        // after bit 7 the line goes high for the stop bit.
                        tx_line   <= (bit_idx == 3'd7) ? 1'b1 : shift_reg[1];
                        if (bit_idx == 3'd7) begin
                            state <= uart_pkg::SER_STOP;
                        end
                    end
                end
                uart_pkg::SER_STOP: begin
                    if (bit_end) begin
                        byte_busy <= 1'b0;
                        byte_done <= 1'b1;
                        state     <= uart_pkg::SER_IDLE;
                    end
                end
                default: state <= uart_pkg::SER_IDLE;
            endcase
        end
    end

    // the requester must wait for the previous frame to finish.
    a_no_req_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        byte_req |-> !byte_busy);
    a_idle_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (state == uart_pkg::SER_IDLE) |-> tx_line);

endmodule

/* design/uart_string_handle.sv */
// ================================================
// UART string handler.
// Collects received bytes into a string closed by
// line idle, and sends a stored string bytewise.
// ================================================
`include "uart_defs.svh"

module uart_string_handle #(
    parameter int BAUD_RATE = `UART_BAUD_RATE
) (
    input  logic                          sys_clk,
    input  logic                          sys_rst_n,
    input  logic [`UART_STR_MAX*8-1:0]    tx_string,
    input  uart_pkg::str_len_t            tx_length,
    input  logic                          tx_req,
    output logic                          tx_busy,
    output logic                          tx_done,
    output logic [`UART_STR_MAX*8-1:0]    rx_string,
    output uart_pkg::str_len_t            rx_length,
    output logic                          rx_busy,
    output logic                          rx_done,
    output uart_pkg::byte_t               last_byte,
    input  logic                          uart_rx_port,
    output logic                          uart_tx_port
);

    localparam int BIT_CYCLES  = `UART_CLK_FREQ / BAUD_RATE;
    localparam int IDLE_CYCLES = `UART_IDLE_BITS * BIT_CYCLES;
    localparam int IDLE_W      = $clog2(IDLE_CYCLES);

    uart_pkg::byte_t      rx_byte;
    logic                 rx_valid;
    uart_pkg::str_len_t   rx_cnt;
    logic [IDLE_W-1:0]    idle_cnt;

    uart_pkg::str_state_t tx_state;
    uart_pkg::str_len_t   tx_idx;
    logic                 byte_req;
    uart_pkg::byte_t      byte_data;
    logic                 byte_busy;
    logic                 byte_done;

    uart_byte_rx #(
        .BAUD_RATE (BAUD_RATE)
    ) u_byte_rx (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .rx_line   (uart_rx_port),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid)
    );

    // the receive buffer doubles as rx_string. It is only read on rx_done.
    always_ff @(posedge sys_clk) begin
        if (rx_valid && (rx_cnt < `UART_STR_MAX)) begin
            rx_string[int'(rx_cnt)*8 +: 8] <= rx_byte;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            rx_cnt    <= '0;
            rx_length <= '0;
            rx_busy   <= 1'b0;
            rx_done   <= 1'b0;
            idle_cnt  <= '0;
            last_byte <= '0;
        end else begin
            rx_done <= 1'b0;
            if (rx_valid) begin
                // every byte restarts the idle gap.
                idle_cnt  <= '0;
                rx_busy   <= 1'b1;
                last_byte <= rx_byte;
                // the count saturates at the buffer size and later bytes are dropped.
                if (rx_cnt < `UART_STR_MAX) begin
                    rx_cnt <= rx_cnt + 1'b1;
                end
            end else if (rx_busy) begin
                if (idle_cnt == IDLE_W'(IDLE_CYCLES - 1)) begin
                    rx_length <= rx_cnt;
                    rx_cnt    <= '0;
                    rx_busy   <= 1'b0;
                    rx_done   <= 1'b1;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    // the byte under the index goes straight to the transmitter.
    assign byte_data = tx_string[int'(tx_idx)*8 +: 8];

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            tx_state <= uart_pkg::STR_IDLE;
            tx_idx   <= '0;
            tx_busy  <= 1'b0;
            tx_done  <= 1'b0;
            byte_req <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (tx_state)
                uart_pkg::STR_IDLE: begin
                    tx_idx <= '0;
                    if (tx_req) begin
                        // an empty string completes at once.
                        if (tx_length == '0) begin
                            tx_done <= 1'b1;
                        end else begin
                            tx_busy  <= 1'b1;
                            tx_state <= uart_pkg::STR_LOAD;
                        end
                    end
                end
                uart_pkg::STR_LOAD: begin
                    // the next byte is requested once the transmitter is free.
                    if (!byte_busy) begin
                        byte_req <= 1'b1;
                        tx_state <= uart_pkg::STR_SEND;
                    end
                end
                uart_pkg::STR_SEND: begin
                    // the transmitter takes the request in this cycle.
                    byte_req <= 1'b0;
                    tx_state <= uart_pkg::STR_WAIT;
                end
                uart_pkg::STR_WAIT: begin
                    if (byte_done) begin
                        if (tx_idx == tx_length - 1'b1) begin
                            tx_busy  <= 1'b0;
                            tx_done  <= 1'b1;
                            tx_state <= uart_pkg::STR_IDLE;
                        end else begin
                            tx_idx   <= tx_idx + 1'b1;
                            tx_state <= uart_pkg::STR_LOAD;
                        end
                    end
                end
                default: tx_state <= uart_pkg::STR_IDLE;
            endcase
        end
    end

    uart_byte_tx #(
        .BAUD_RATE (BAUD_RATE)
    ) u_byte_tx (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .byte_req  (byte_req),
        .byte_data (byte_data),
        .tx_line   (uart_tx_port),
        .byte_busy (byte_busy),
        .byte_done (byte_done)
    );

    a_rx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        rx_done |=> !rx_done);
    // the top level must not start a string while one is in flight.
    a_no_req_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        tx_req |-> !tx_busy);

endmodule

/* design/uart_try.sv */
// ================================================
// UART line echo top level.
// Sends every received string back with CR LF.
// ================================================
`include "uart_defs.svh"

module uart_try #(
    parameter int BAUD_RATE = `UART_BAUD_RATE
) (
    input  logic               sys_clk,
    input  logic               sys_rst_n,
    output uart_pkg::byte_t    uart_rx_data,
    input  logic               uart_rx_port,
    output logic               uart_tx_port
);

    logic [`UART_STR_MAX*8-1:0] rx_str;
    uart_pkg::str_len_t         rx_len;
    logic                       rx_done;

    logic [`UART_STR_MAX*8-1:0] echo_str;
    uart_pkg::str_len_t         keep_len;
    logic [`UART_STR_MAX*8-1:0] pend_str;
    uart_pkg::str_len_t         pend_len;
    logic                       pend_flag;

    logic [`UART_STR_MAX*8-1:0] tx_str;
    uart_pkg::str_len_t         tx_len;
    logic                       tx_req;
    logic                       tx_busy;
    logic                       tx_done;

    // two bytes are reserved at the end of the buffer for the line ending.
    always_comb begin
        keep_len = (rx_len > (`UART_STR_MAX - 2)) ? uart_pkg::str_len_t'(`UART_STR_MAX - 2)
                                                 : rx_len;
        echo_str = rx_str;
        echo_str[int'(keep_len)*8 +: 16] = 16'h0a0d;
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            pend_flag <= 1'b0;
            tx_req    <= 1'b0;
        end else begin
            tx_req <= 1'b0;
            // a new string replaces any pending one that has not started.
            if (rx_done) begin
                pend_str  <= echo_str;
                pend_len  <= keep_len + 8'd2;
                pend_flag <= 1'b1;
            end else if (pend_flag && !tx_busy) begin
                tx_str    <= pend_str;
                tx_len    <= pend_len;
                tx_req    <= 1'b1;
                pend_flag <= 1'b0;
            end
        end
    end

    uart_string_handle #(
        .BAUD_RATE (BAUD_RATE)
    ) u_string_handle (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .tx_string    (tx_str),
        .tx_length    (tx_len),
        .tx_req       (tx_req),
        .tx_busy      (tx_busy),
        .tx_done      (tx_done),
        .rx_string    (rx_str),
        .rx_length    (rx_len),
        .rx_busy      (),
        .rx_done      (rx_done),
        .last_byte    (uart_rx_data),
        .uart_rx_port (uart_rx_port),
        .uart_tx_port (uart_tx_port)
    );

    // an accepted request is always followed by busy or an immediate done.
    a_req_taken: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        tx_req |=> (tx_busy || tx_done));

endmodule

/* tb/tb_clk_gen.sv */
// ================================================
// Testbench clock and reset source.
// 8 ns clock, reset low for the first 10 cycles.
// ================================================
module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic sys_clk,
    output logic sys_rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // free-running clock, low for the first half period.
    initial begin
        sys_clk = 1'b0;
        forever #(PERIOD_NS / 2) sys_clk = ~sys_clk;
    end

    // the reset is synchronous, so it is released on a rising edge.
    initial begin
        sys_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
    end

endmodule

/* tb/tb_uart_try.sv */
// ================================================
// UART line echo testbench.
// A serial host sends strings and a line monitor
// checks the echo with CR LF on uart_tx_port.
// ================================================
`include "uart_defs.svh"

module tb_uart_try;
    timeunit 1ns;
    timeprecision 1ps;

    // the bit period in clock cycles is rounded down.
    localparam int BIT_CYCLES   = `UART_CLK_FREQ / `UART_BAUD_RATE;
    localparam int BYTE_TIMEOUT = 60 * BIT_CYCLES;
    localparam int RST_TIMEOUT  = 100;
    localparam int STR_KEEP     = `UART_STR_MAX - 2;

    logic       sys_clk;
    logic       sys_rst_n;
    logic       uart_rx_port;
    logic       uart_tx_port;
    logic [7:0] uart_rx_data;

    // the host string and the index of a frame sent with a low stop bit.
    logic [7:0]  host_buf [0:255];
    int          host_len;
    int          bad_idx;
    logic [7:0]  exp_q [$];
    logic [7:0]  got_q [$];
    logic [31:0] rnd;
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;

    tb_clk_gen u_clk_gen (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n)
    );

    uart_try UUT (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .uart_rx_data (uart_rx_data),
        .uart_rx_port (uart_rx_port),
        .uart_tx_port (uart_tx_port)
    );

    // the echo monitor finds each start bit and samples every bit at its middle.
    // outputs are read on the falling edge, where they are stable.
    initial begin : echo_monitor
        logic [7:0] bits;
        int k;
        forever begin
            @(negedge sys_clk);
            if (sys_rst_n && !uart_tx_port) begin
                repeat (BIT_CYCLES / 2) @(negedge sys_clk);
                // a start bit that is gone at mid-bit is a glitch and is ignored.
                if (!uart_tx_port) begin
                    for (k = 0; k < 8; k++) begin
                        repeat (BIT_CYCLES) @(negedge sys_clk);
                        bits[k] = uart_tx_port;
                    end
                    repeat (BIT_CYCLES) @(negedge sys_clk);
                    assert (uart_tx_port == 1'b1) else begin
                        $display("echo frame for byte %h has a low stop bit", bits);
                        err_cnt++;
                    end
                    got_q.push_back(bits);
                end
            end
        end
    end

    // one bit on the host line, held for a full bit period.
    task automatic drive_bit(input logic b);
        @(posedge sys_clk);
        uart_rx_port <= b;
        repeat (BIT_CYCLES - 1) @(posedge sys_clk);
    endtask

    // an 8N1 frame, LSB first. A low stop_bit makes a framing error.
    task automatic send_byte(input logic [7:0] data, input logic stop_bit);
        int k;
        drive_bit(1'b0);
        for (k = 0; k < 8; k++) begin
            drive_bit(data[k]);
        end
        drive_bit(stop_bit);
    endtask

    task automatic idle_bits(input int n);
        int k;
        for (k = 0; k < n; k++) begin
            drive_bit(1'b1);
        end
    endtask

    // sends host_buf and queues the echo that the line protocol promises.
    // only good bytes count and the first 126 of them are kept before CR and LF.
    task automatic send_string();
        int i;
        int kept;
        kept = 0;
        for (i = 0; i < host_len; i++) begin
            if (i == bad_idx) begin
                send_byte(host_buf[i], 1'b0);
                // a short high gap lets the receiver leave the broken frame.
                idle_bits(2);
            end else begin
                send_byte(host_buf[i], 1'b1);
                @(negedge sys_clk);
                assert (uart_rx_data == host_buf[i]) else begin
                    $display("[FAIL] uart_rx_data: expected %h, got %h",
                             host_buf[i], uart_rx_data);
                    err_cnt++;
                end
                if (kept < STR_KEEP) begin
                    exp_q.push_back(host_buf[i]);
                end
                kept++;
            end
        end
        exp_q.push_back(8'h0d);
        exp_q.push_back(8'h0a);
    endtask

    task automatic fill_random(input int len);
        int i;
        host_len = len;
        bad_idx  = -1;
        for (i = 0; i < len; i++) begin
            rnd = $urandom();
            host_buf[i] = rnd[7:0];
        end
    endtask

    task automatic wait_echo_byte(output bit got_one);
        int cyc;
        got_one = 1'b0;
        for (cyc = 0; cyc < BYTE_TIMEOUT && !got_one; cyc++) begin
            @(negedge sys_clk);
            if (got_q.size() > 0) begin
                got_one = 1'b1;
            end
        end
    endtask

    // compares the monitor's bytes in order with the expected echo.
    task automatic check_echo();
        bit got_one;
        logic [7:0] exp_b;
        logic [7:0] got_b;
        while (exp_q.size() > 0) begin
            exp_b = exp_q.pop_front();
            wait_echo_byte(got_one);
            if (!got_one) begin
                $display("timed out waiting for echo byte %h on uart_tx_port", exp_b);
                err_cnt++;
                exp_q.delete();
            end else begin
                got_b = got_q.pop_front();
                assert (got_b == exp_b) else begin
                    $display("[FAIL] uart_tx_port: expected %h, got %h", exp_b, got_b);
                    err_cnt++;
                end
            end
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        assert (got_q.size() == 0) else begin
            $display("%0d extra bytes came back on uart_tx_port", got_q.size());
            err_cnt++;
            got_q.delete();
        end
        if (err_cnt == err_before) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed", name);
        end
    endtask

    // with no input the transmit line must idle high.
    task automatic check_idle_line();
        int cyc;
        bit seen_low;
        seen_low = 1'b0;
        for (cyc = 0; cyc < 100 * BIT_CYCLES; cyc++) begin
            @(negedge sys_clk);
            if (!seen_low) begin
                assert (uart_tx_port == 1'b1) else begin
                    $display("[FAIL] uart_tx_port: expected %h, got %h", 1'b1, uart_tx_port);
                    err_cnt++;
                    seen_low = 1'b1;
                end
            end
        end
    endtask

    initial begin : main_seq
        int seed;
        int cyc;
        int err_before;
        int len_a;
        seed = 32'h3d1a17ce;
        rnd = $urandom(seed);
        uart_rx_port = 1'b1;
        err_cnt  = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        host_len = 0;
        bad_idx  = -1;

        for (cyc = 0; cyc < RST_TIMEOUT && sys_rst_n !== 1'b1; cyc++) begin
            @(posedge sys_clk);
        end
        if (sys_rst_n !== 1'b1) begin
            $display("reset was never released, no test was run");
            err_cnt++;
            fail_cnt++;
        end else begin
            err_before = err_cnt;
            check_idle_line();
            finish_test("idle_after_reset", err_before);

            err_before = err_cnt;
            fill_random(1 + int'($urandom() % 20));
            send_string();
            idle_bits(`UART_IDLE_BITS + 10);
            check_echo();
            finish_test("random_string", err_before);

            // a string longer than the buffer has its echo cut to 126 bytes.
            err_before = err_cnt;
            fill_random(130);
            send_string();
            idle_bits(`UART_IDLE_BITS + 10);
            check_echo();
            finish_test("long_string", err_before);

            // the bad frame is the last one. Between good bytes it would stretch
            // the gap past the idle limit and split the string.
            err_before = err_cnt;
            fill_random(6);
            bad_idx = 5;
            send_string();
            idle_bits(`UART_IDLE_BITS + 10);
            check_echo();
            finish_test("bad_stop_bit", err_before);

            // the second string ends while the first echo is still on the line.
            err_before = err_cnt;
            len_a = 12;
            fill_random(len_a);
            send_string();
            idle_bits(`UART_IDLE_BITS + 2);
            fill_random(8);
            send_string();
            idle_bits(`UART_IDLE_BITS + 10);
            check_echo();
            finish_test("overlapped_strings", err_before);
        end

        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+design
design/uart_pkg.sv
design/uart_byte_rx.sv
design/uart_byte_tx.sv
design/uart_string_handle.sv
design/uart_try.sv
tb/tb_clk_gen.sv
tb/tb_uart_try.sv
